/* Makefile */
# Verilator build and run for the autotest sequencer

VERILATOR ?= verilator
TOP       ?= tb_autotest
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/autotest_pkg.sv */
package autotest_pkg;

  typedef logic [7:0]   byte_t;
  typedef logic [31:0]  block_addr_t;
  typedef logic [9:0]   byte_idx_t;
  typedef logic [127:0] key_t;
  typedef logic [31:0]  cycles_t;

  // parameters handed to the key-derivation core
  typedef struct packed {
    logic [63:0] salt;
    logic [31:0] count;
    logic [31:0] password;
  } uut_params_t;

  // header as it sits msb first at the start of a block
  typedef struct packed {
    logic [31:0] signature;
    logic [7:0]  iterations;
    uut_params_t params;
  } test_header_t;

  // sd host strobes
  typedef struct packed {
    logic rst;
    logic r_block;
    logic r_byte;
    logic w_block;
    logic w_byte;
  } spi_cmd_t;

  localparam int BLOCK_BYTES  = 512;
  localparam int HEADER_BYTES = 21;

  // result block layout
  // header echo in 0..20, key lsb first, cycles lsb first, then payload
  localparam int KEY_FIRST     = 21;
  localparam int KEY_BYTES     = 16;
  localparam int CYCLES_FIRST  = KEY_FIRST + KEY_BYTES;
  localparam int CYCLES_BYTES  = 4;
  localparam int PAYLOAD_FIRST = CYCLES_FIRST + CYCLES_BYTES;

  localparam logic [31:0] TEST_SIGNATURE = 32'hAABBCCDD;
  localparam block_addr_t BLOCK_BASE     = 32'h00100000;

endpackage

/* rtl/autotest_seq.sv */
module autotest_seq #(
  parameter int unsigned TIMEOUT_CYCLES = 115343360
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       spi_busy_i,
  output autotest_pkg::spi_cmd_t     spi_cmd_o,
  output autotest_pkg::block_addr_t  spi_block_addr_o,
  output autotest_pkg::byte_idx_t    byte_idx_o,
  output logic                       hdr_we_o,
  output logic                       ram_we_o,
  output logic                       data_we_o,
  output logic                       key_we_o,
  input  autotest_pkg::test_header_t header_i,
  output autotest_pkg::cycles_t      cycles_o,
  output logic                       uut_rst_o,
  input  logic                       uut_end_i,
  output logic                       done_o
);

  typedef enum logic [3:0] {
    S_IDLE, S_SPI_RST, S_SPI_RST_WAIT,
    S_RD_OPEN, S_RD_OPEN_WAIT, S_RD_DATA, S_RD_BYTE, S_RD_WAIT,
    S_CHECK, S_TEST,
    S_WR_OPEN, S_WR_LOAD, S_WR_BYTE, S_WR_WAIT,
    S_NEXT, S_HALT
  } state_t;

  state_t                    state_q;
  state_t                    state_d;
  autotest_pkg::byte_idx_t   byte_cnt;
  autotest_pkg::block_addr_t block_cnt;
  autotest_pkg::cycles_t     cycle_cnt;
  logic [7:0]                run_cnt;
  logic [7:0]                run_target;
  logic                      byte_clr;
  logic                      byte_inc;
  logic                      run_clr;
  logic                      run_inc;
  logic                      block_inc;
  logic                      cyc_clr;
  logic                      cyc_inc;
  logic                      last_byte;
  logic                      test_done;
  logic                      runs_done;

  assign last_byte = (byte_cnt == autotest_pkg::byte_idx_t'(autotest_pkg::BLOCK_BYTES));
  assign test_done = uut_end_i || (cycle_cnt == autotest_pkg::cycles_t'(TIMEOUT_CYCLES));

  // zero iterations still runs once
  assign run_target = (header_i.iterations == 8'd0) ? 8'd1 : header_i.iterations;
  assign runs_done  = (run_cnt >= run_target - 8'd1);

  assign byte_idx_o       = byte_cnt;
  assign spi_block_addr_o = autotest_pkg::BLOCK_BASE + block_cnt;
  assign cycles_o         = cycle_cnt;
  assign uut_rst_o        = (state_q != S_TEST);
  assign done_o           = (state_q == S_HALT);

  always_comb
  begin
    state_d   = state_q;
    spi_cmd_o = '0;
    hdr_we_o  = 1'b0;
    ram_we_o  = 1'b0;
    data_we_o = 1'b0;
    key_we_o  = 1'b0;
    byte_clr  = 1'b0;
    byte_inc  = 1'b0;
    run_clr   = 1'b0;
    run_inc   = 1'b0;
    block_inc = 1'b0;
    cyc_clr   = 1'b0;
    cyc_inc   = 1'b0;
    case (state_q)
      S_IDLE:
      begin
        byte_clr = 1'b1;
        run_clr  = 1'b1;
        state_d  = S_SPI_RST;
      end
      S_SPI_RST:
      begin
        spi_cmd_o.rst = 1'b1;
        if (spi_busy_i)
          state_d = S_SPI_RST_WAIT;
      end
      S_SPI_RST_WAIT:
      begin
        byte_clr = 1'b1;
        if (!spi_busy_i)
          state_d = S_RD_OPEN;
      end
      S_RD_OPEN:
      begin
        spi_cmd_o.r_block = 1'b1;
        if (spi_busy_i)
          state_d = S_RD_OPEN_WAIT;
      end
      S_RD_OPEN_WAIT:
      begin
        spi_cmd_o.r_block = 1'b1;
        if (!spi_busy_i)
          state_d = S_RD_DATA;
      end
      S_RD_DATA:
      begin
        if (last_byte)
          state_d = S_CHECK;
        else
        begin
          // header bytes to the capture regs, the rest to ram
          spi_cmd_o.r_block = 1'b1;
          if (byte_cnt < autotest_pkg::HEADER_BYTES)
            hdr_we_o = 1'b1;
          else
            ram_we_o = 1'b1;
          state_d = S_RD_BYTE;
        end
      end
      S_RD_BYTE:
      begin
        spi_cmd_o.r_block = 1'b1;
        spi_cmd_o.r_byte  = 1'b1;
        if (spi_busy_i)
        begin
          byte_inc = 1'b1;
          state_d  = S_RD_WAIT;
        end
      end
      S_RD_WAIT:
      begin
        spi_cmd_o.r_block = 1'b1;
        if (!spi_busy_i)
          state_d = S_RD_DATA;
      end
      S_CHECK:
      begin
        if (header_i.signature == autotest_pkg::TEST_SIGNATURE)
        begin
          cyc_clr = 1'b1;
          state_d = S_TEST;
        end
        else
          state_d = S_HALT;
      end
      S_TEST:
      begin
        if (test_done)
        begin
          key_we_o = 1'b1;
          byte_clr = 1'b1;
          state_d  = S_WR_OPEN;
        end
        else
          cyc_inc = 1'b1;
      end
      S_WR_OPEN:
      begin
        spi_cmd_o.w_block = 1'b1;
        if (!spi_busy_i)
          state_d = S_WR_LOAD;
      end
      S_WR_LOAD:
      begin
        if (last_byte)
          state_d = S_NEXT;
        else
        begin
          spi_cmd_o.w_block = 1'b1;
          data_we_o         = 1'b1;
          state_d           = S_WR_BYTE;
        end
      end
      S_WR_BYTE:
      begin
        spi_cmd_o.w_block = 1'b1;
        spi_cmd_o.w_byte  = 1'b1;
        if (spi_busy_i)
        begin
          byte_inc = 1'b1;
          state_d  = S_WR_WAIT;
        end
      end
      S_WR_WAIT:
      begin
        spi_cmd_o.w_block = 1'b1;
        if (!spi_busy_i)
          state_d = S_WR_LOAD;
      end
      S_NEXT:
      begin
        if (runs_done)
        begin
          block_inc = 1'b1;
          state_d   = S_IDLE;
        end
        else
        begin
          run_inc = 1'b1;
          state_d = S_SPI_RST;
        end
      end
      // halted for good on a bad signature
      S_HALT:
        state_d = S_HALT;
      default:
        state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= S_IDLE;
      byte_cnt  <= '0;
      block_cnt <= '0;
      run_cnt   <= '0;
      cycle_cnt <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (byte_clr)
        byte_cnt <= '0;
      else if (byte_inc)
        byte_cnt <= byte_cnt + 1'b1;
      if (run_clr)
        run_cnt <= '0;
      else if (run_inc)
        run_cnt <= run_cnt + 1'b1;
      if (block_inc)
        block_cnt <= block_cnt + 1'b1;
      if (cyc_clr)
        cycle_cnt <= '0;
      else if (cyc_inc)
        cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(spi_cmd_o.r_block && spi_cmd_o.w_block));

  // core must be held in reset through any card transfer
  a_uut_held: assert property (@(posedge clk) disable iff (rst)
    (spi_cmd_o.r_block || spi_cmd_o.w_block) |-> uut_rst_o);

endmodule

/* rtl/autotest_top.sv */
module autotest_top #(
  parameter int unsigned TIMEOUT_CYCLES = 115343360,
  parameter int          RAM_DEPTH      = autotest_pkg::BLOCK_BYTES
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      spi_busy_i,
  input  autotest_pkg::byte_t       spi_data_i,
  output autotest_pkg::spi_cmd_t    spi_cmd_o,
  output autotest_pkg::byte_t       spi_data_o,
  output autotest_pkg::block_addr_t spi_block_addr_o,
  output logic                      uut_rst_o,
  output autotest_pkg::uut_params_t uut_params_o,
  input  logic                      uut_end_i,
  input  autotest_pkg::key_t        uut_key_i,
  output logic                      done_o
);

  autotest_pkg::byte_idx_t    byte_idx;
  autotest_pkg::test_header_t header;
  autotest_pkg::cycles_t      cycles;
  autotest_pkg::byte_t        ram_data;
  logic                       hdr_we;
  logic                       ram_we;
  logic                       data_we;
  logic                       key_we;

  // params stay static while the core runs since the header only loads during a read
  assign uut_params_o = header.params;

  autotest_seq #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) autotest_seq_inst (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .spi_cmd_o        (spi_cmd_o),
    .spi_block_addr_o (spi_block_addr_o),
    .byte_idx_o       (byte_idx),
    .hdr_we_o         (hdr_we),
    .ram_we_o         (ram_we),
    .data_we_o        (data_we),
    .key_we_o         (key_we),
    .header_i         (header),
    .cycles_o         (cycles),
    .uut_rst_o        (uut_rst_o),
    .uut_end_i        (uut_end_i),
    .done_o           (done_o)
  );

  header_capture header_capture_inst (
    .clk        (clk),
    .rst        (rst),
    .we_i       (hdr_we),
    .byte_idx_i (byte_idx),
    .data_i     (spi_data_i),
    .header_o   (header)
  );

  payload_ram #(
    .RAM_DEPTH(RAM_DEPTH)
  ) payload_ram_inst (
    .clk    (clk),
    .we_i   (ram_we),
    .addr_i (byte_idx),
    .data_i (spi_data_i),
    .data_o (ram_data)
  );

  result_serializer result_serializer_inst (
    .clk        (clk),
    .rst        (rst),
    .key_we_i   (key_we),
    .key_i      (uut_key_i),
    .data_we_i  (data_we),
    .byte_idx_i (byte_idx),
    .header_i   (header),
    .cycles_i   (cycles),
    .ram_data_i (ram_data),
    .data_o     (spi_data_o)
  );

endmodule

/* rtl/header_capture.sv */
module header_capture (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       we_i,
  input  autotest_pkg::byte_idx_t    byte_idx_i,
  input  autotest_pkg::byte_t        data_i,
  output autotest_pkg::test_header_t header_o
);

  autotest_pkg::test_header_t hdr_q;
  logic [4:0]                 slot;

  // byte 0 lands in the top byte of the struct
  assign slot = 5'(autotest_pkg::HEADER_BYTES - 1 - int'(byte_idx_i));

  always_ff @(posedge clk)
  begin
    if (rst)
      hdr_q <= '0;
    else if (we_i)
      hdr_q[{slot, 3'b000} +: 8] <= data_i;
  end

  assign header_o = hdr_q;

  // sequencer steers non-header bytes to the ram
  a_hdr_range: assert property (@(posedge clk) disable iff (rst)
    we_i |-> (byte_idx_i < autotest_pkg::HEADER_BYTES));

endmodule

/* rtl/payload_ram.sv */
module payload_ram #(
  parameter int RAM_DEPTH = 512
) (
  input  logic                    clk,
  input  logic                    we_i,
  input  autotest_pkg::byte_idx_t addr_i,
  input  autotest_pkg::byte_t     data_i,
  output autotest_pkg::byte_t     data_o
);

  localparam int AW = $clog2(RAM_DEPTH);

  autotest_pkg::byte_t mem [RAM_DEPTH];
  logic [AW-1:0]       addr;

  // index 512 wraps to slot 0 and is never written
  assign addr = addr_i[AW-1:0];

  always_ff @(posedge clk)
  begin
    if (we_i)
      mem[addr] <= data_i;
    data_o <= mem[addr];
  end

endmodule

/* rtl/result_serializer.sv */
module result_serializer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       key_we_i,
  input  autotest_pkg::key_t         key_i,
  input  logic                       data_we_i,
  input  autotest_pkg::byte_idx_t    byte_idx_i,
  input  autotest_pkg::test_header_t header_i,
  input  autotest_pkg::cycles_t      cycles_i,
  input  autotest_pkg::byte_t        ram_data_i,
  output autotest_pkg::byte_t        data_o
);

  autotest_pkg::key_t  key_q;
  autotest_pkg::byte_t sel;
  logic [4:0]          hdr_slot;
  logic [3:0]          key_off;
  logic [1:0]          cyc_off;

  // header echo goes msb first, key and cycles lsb first
  assign hdr_slot = 5'(autotest_pkg::HEADER_BYTES - 1 - int'(byte_idx_i));
  assign key_off  = 4'(int'(byte_idx_i) - autotest_pkg::KEY_FIRST);
  assign cyc_off  = 2'(int'(byte_idx_i) - autotest_pkg::CYCLES_FIRST);

  always_ff @(posedge clk)
  begin
    if (key_we_i)
      key_q <= key_i;
  end

  always_comb
  begin
    if (byte_idx_i < autotest_pkg::HEADER_BYTES)
      sel = header_i[{hdr_slot, 3'b000} +: 8];
    else if (byte_idx_i < autotest_pkg::CYCLES_FIRST)
      sel = key_q[{key_off, 3'b000} +: 8];
    else if (byte_idx_i < autotest_pkg::PAYLOAD_FIRST)
      sel = cycles_i[{cyc_off, 3'b000} +: 8];
    else
      sel = ram_data_i;
  end

  // write data held stable while w_byte is up
  always_ff @(posedge clk)
  begin
    if (rst)
      data_o <= '0;
    else if (data_we_i)
      data_o <= sel;
  end

endmodule

/* sim.f */
rtl/autotest_pkg.sv
rtl/autotest_seq.sv
rtl/header_capture.sv
rtl/payload_ram.sv
rtl/result_serializer.sv
rtl/autotest_top.sv
test/sd_card_model.sv
test/tb_autotest.sv

/* test/sd_card_model.sv */
module sd_card_model (
  input  logic                      clk,
  input  logic                      rst,
  input  autotest_pkg::spi_cmd_t    spi_cmd_i,
  input  autotest_pkg::byte_t       spi_data_i,
  input  autotest_pkg::block_addr_t spi_block_addr_i,
  output logic                      spi_busy_o,
  output autotest_pkg::byte_t       spi_data_o,
  output int                        wr_count_o,
  output autotest_pkg::block_addr_t wr_addr_o
);
  timeunit 1ns;
  timeprecision 1ps;

  autotest_pkg::byte_t store [16][512];
  autotest_pkg::byte_t wr_data [512];
  logic [31:0]         rand_q = 32'h159c_2461;
  int                  busy_cnt;
  int                  ptr;
  int                  blk;
  logic                rd_open;
  logic                wr_open;

  // busy of 1 to 4 cycles
  function automatic int busy_len();
    rand_q = rand_q * 32'd1103515245 + 32'd12345;
    return 1 + int'(rand_q[17:16]);
  endfunction

  task automatic start_busy();
    busy_cnt = busy_len();
    spi_busy_o <= 1'b1;
  endtask

  always @(negedge clk)
  begin
    if (rst)
    begin
      busy_cnt = 0;
      rd_open = 1'b0;
      wr_open = 1'b0;
      spi_busy_o <= 1'b0;
    end
    else if (busy_cnt != 0)
    begin
      busy_cnt = busy_cnt - 1;
      if (busy_cnt == 0)
        spi_busy_o <= 1'b0;
    end
    else if (spi_cmd_i.rst)
      start_busy();
    else if (spi_cmd_i.r_block && !rd_open)
    begin
      rd_open = 1'b1;
      ptr = 0;
      blk = int'(spi_block_addr_i[3:0]);
      spi_data_o <= store[blk][0];
      start_busy();
    end
    else if (spi_cmd_i.r_byte && rd_open)
    begin
      ptr = ptr + 1;
      if (ptr < 512)
        spi_data_o <= store[blk][ptr];
      start_busy();
    end
    else if (spi_cmd_i.w_block && !wr_open)
    begin
      wr_open = 1'b1;
      ptr = 0;
      blk = int'(spi_block_addr_i[3:0]);
      wr_addr_o <= spi_block_addr_i;
    end
    else if (spi_cmd_i.w_byte && wr_open)
    begin
      // byte latched as busy rises
      wr_data[ptr] <= spi_data_i;
      store[blk][ptr] = spi_data_i;
      ptr = ptr + 1;
      start_busy();
    end
    else if (!spi_cmd_i.w_block && wr_open)
    begin
      wr_open = 1'b0;
      wr_count_o <= wr_count_o + 1;
    end
    else if (!spi_cmd_i.r_block)
      rd_open = 1'b0;
  end

  initial
  begin
    spi_busy_o = 1'b0;
    spi_data_o = '0;
    wr_count_o = 0;
    wr_addr_o  = '0;
  end

endmodule

/* test/tb_autotest.sv */
module tb_autotest;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROWS = 4;
  localparam int TIMEOUT = 300;
  localparam int CYCLE_LIMIT = 20000 * ROWS;

  typedef struct packed {
    logic [31:0]        signature;
    logic [7:0]         iterations;
    logic [63:0]        salt;
    logic [31:0]        count;
    logic [31:0]        password;
    logic [31:0]        latency;
    autotest_pkg::key_t key;
  } row_t;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      spi_busy;
  autotest_pkg::byte_t       spi_rd_data;
  autotest_pkg::spi_cmd_t    spi_cmd;
  autotest_pkg::byte_t       spi_wr_data;
  autotest_pkg::block_addr_t spi_addr;
  logic                      uut_rst;
  autotest_pkg::uut_params_t uut_params;
  logic                      uut_end;
  autotest_pkg::key_t        uut_key;
  logic                      done;
  int                        wr_count;
  autotest_pkg::block_addr_t wr_addr;

  row_t                rows [ROWS];
  autotest_pkg::byte_t expect_blk [ROWS][512];
  logic [31:0]         rand_q = 32'h159c_2461;
  int                  cur_row;
  int                  cycle_cnt;
  int                  uut_starts;
  int                  uut_edges;
  logic                uut_rst_prev;

  always #50 clk = ~clk;

  autotest_top #(
    .TIMEOUT_CYCLES(TIMEOUT),
    .RAM_DEPTH(autotest_pkg::BLOCK_BYTES)
  ) autotest_top_inst (
    .clk(clk), .rst(rst), .spi_busy_i(spi_busy), .spi_data_i(spi_rd_data),
    .spi_cmd_o(spi_cmd), .spi_data_o(spi_wr_data), .spi_block_addr_o(spi_addr),
    .uut_rst_o(uut_rst), .uut_params_o(uut_params), .uut_end_i(uut_end),
    .uut_key_i(uut_key), .done_o(done)
  );

  sd_card_model sd_card_model_inst (
    .clk(clk), .rst(rst), .spi_cmd_i(spi_cmd), .spi_data_i(spi_wr_data),
    .spi_block_addr_i(spi_addr), .spi_busy_o(spi_busy), .spi_data_o(spi_rd_data),
    .wr_count_o(wr_count), .wr_addr_o(wr_addr)
  );

  function automatic autotest_pkg::byte_t rand_byte();
    rand_q = rand_q * 32'd1103515245 + 32'd12345;
    return rand_q[23:16];
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string name, input autotest_pkg::byte_t got,
                            input autotest_pkg::byte_t exp);
    if (got !== exp)
      stop_run($sformatf("Error at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input autotest_pkg::block_addr_t got,
                            input autotest_pkg::block_addr_t exp);
    if (got !== exp)
      stop_run($sformatf("Error at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_params(input string name, input autotest_pkg::uut_params_t got,
                              input autotest_pkg::uut_params_t exp);
    if (got !== exp)
      stop_run($sformatf("Error at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_cycles(input string name, input autotest_pkg::cycles_t got,
                              input autotest_pkg::cycles_t exp);
    if (got !== exp)
      stop_run($sformatf("Error at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  // uut model raises its end strobe after the row latency in edges out of reset
  always @(negedge clk)
  begin
    uut_key <= rows[cur_row].key;
    if (uut_rst)
    begin
      uut_edges = 0;
      uut_end <= 1'b0;
    end
    else
    begin
      if (uut_edges >= int'(rows[cur_row].latency))
        uut_end <= 1'b1;
      uut_edges = uut_edges + 1;
    end
  end

  always @(negedge clk)
  begin
    autotest_pkg::uut_params_t exp;
    exp.salt     = rows[cur_row].salt;
    exp.count    = rows[cur_row].count;
    exp.password = rows[cur_row].password;
    if (!rst && uut_rst_prev && !uut_rst)
    begin
      uut_starts = uut_starts + 1;
      check_params("uut_params_o", uut_params, exp);
    end
    uut_rst_prev = uut_rst;
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT)
      stop_run("the run did not finish within the cycle limit");
  end

  task automatic check_result(input int r);
    autotest_pkg::cycles_t got_cyc;
    logic [31:0]           exp_cyc;
    check_addr("wr_addr", wr_addr, autotest_pkg::BLOCK_BASE + 32'(r));
    for (int i = 0; i < 512; i++)
    begin
      if (i >= autotest_pkg::KEY_FIRST && i < autotest_pkg::CYCLES_FIRST)
        check_byte($sformatf("key byte %0d", i), sd_card_model_inst.wr_data[i],
                   rows[r].key[8 * (i - autotest_pkg::KEY_FIRST) +: 8]);
      else if (i >= autotest_pkg::CYCLES_FIRST && i < autotest_pkg::PAYLOAD_FIRST)
        got_cyc[8 * (i - autotest_pkg::CYCLES_FIRST) +: 8] = sd_card_model_inst.wr_data[i];
      else
        check_byte($sformatf("block byte %0d", i), sd_card_model_inst.wr_data[i],
                   expect_blk[r][i]);
    end
    exp_cyc = (rows[r].latency > TIMEOUT) ? 32'(TIMEOUT) : rows[r].latency;
    check_cycles("cycles", got_cyc, exp_cyc);
  endtask

  initial
  begin
    int seen;
    int runs;
    int starts;
    logic [167:0] hdr;
    rst = 1'b1;
    uut_end = 1'b0;
    uut_key = '0;
    cur_row = 0;
    cycle_cnt = 0;
    uut_starts = 0;
    uut_edges = 0;
    uut_rst_prev = 1'b1;
    // second row runs into the timeout, last row is the bad signature
    rows[0] = '{32'hAABBCCDD, 8'd2, 64'h0123_4567_89ab_cdef, 32'd1000, 32'h7061_7373,
                32'd10, 128'h00112233_44556677_8899aabb_ccddeeff};
    rows[1] = '{32'hAABBCCDD, 8'd0, 64'hfeed_face_cafe_beef, 32'd4096, 32'h5365_6372,
                32'd305, 128'hdeadbeef_01020304_a5a55a5a_0f1e2d3c};
    rows[2] = '{32'hAABBCCDD, 8'd1, 64'h1111_2222_3333_4444, 32'd1, 32'h0000_0001,
                32'd1, 128'h13579bdf_2468ace0_fdb97531_0eca8642};
    rows[3] = '{32'h1234_5678, 8'd1, 64'h0, 32'd0, 32'd0, 32'd5, 128'h0};
    for (int r = 0; r < ROWS; r++)
    begin
      hdr = {rows[r].signature, rows[r].iterations, rows[r].salt, rows[r].count,
             rows[r].password};
      for (int i = 0; i < 512; i++)
      begin
        if (i < autotest_pkg::HEADER_BYTES)
          expect_blk[r][i] = hdr[8 * (autotest_pkg::HEADER_BYTES - 1 - i) +: 8];
        else
          expect_blk[r][i] = rand_byte();
        sd_card_model_inst.store[r][i] = expect_blk[r][i];
      end
    end
    repeat (8) @(negedge clk);
    if (spi_cmd !== '0 || done !== 1'b0 || uut_rst !== 1'b1)
      stop_run("outputs are not in their reset state during reset");
    rst = 1'b0;
    seen = 0;
    for (int r = 0; r < ROWS - 1; r++)
    begin
      cur_row = r;
      runs = (rows[r].iterations == 8'd0) ? 1 : int'(rows[r].iterations);
      for (int k = 0; k < runs; k++)
      begin
        while (wr_count == seen)
          @(negedge clk);
        seen = seen + 1;
        check_result(r);
      end
    end
    cur_row = ROWS - 1;
    starts = uut_starts;
    while (!done)
      @(negedge clk);
    repeat (50)
    begin
      @(negedge clk);
      if (!done)
        stop_run("done_o dropped after the sequencer halted");
    end
    if (wr_count != seen)
      stop_run("a block was written for the bad signature row");
    else if (uut_starts != starts)
      stop_run("the uut left reset for the bad signature row");
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule
